//--- files.f
+incdir+hw
hw/timers_pkg.sv
hw/timer_pulse.sv
hw/pulse_edge_sync.sv
hw/timers.sv
hw/timer_regs.sv
hw/timers_top.sv
verification/timers_assertions.sv
verification/tb_timers.sv

//--- Bender.yml
package:
  name: timers

sources:
  - include_dirs:
      - hw
    files:
      - hw/timers_pkg.sv
      - hw/timer_pulse.sv
      - hw/pulse_edge_sync.sv
      - hw/timers.sv
      - hw/timer_regs.sv
      - hw/timers_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/timers_assertions.sv
      - verification/tb_timers.sv

//--- verification/tb_timers.sv
// Table-driven testbench for timers_top; slow pulses sampled on clk_15p36 edges
// Table periods must be 0 or at least 2, windows at least 3 slow cycles
`timescale 1ns/1ps
`include "timers_consts.svh"

module tb_timers;

    localparam int NUM_ROWS = 6;
    localparam int SETTLE   = 8;

    logic                  clk_15p36;
    logic                  clk_368p64;
    logic                  arst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    timers_pkg::apb_addr_t paddr;
    timers_pkg::apb_data_t pwdata;
    timers_pkg::apb_data_t prdata;
    logic                  pslverr;
    logic                  timer_pulse_xssi;
    logic                  timer_pulse_xssi_x3;
    logic                  timer_pulse_tssi_pap_x3;

    // Rows of XSSI period, PAP period, enables {pap, xssi} and window
    int         row_xssi_n [NUM_ROWS] = '{50, 13, 0, 2, 37, 3};
    int         row_pap_n  [NUM_ROWS] = '{7, 154, 9, 0, 5, 2};
    logic [1:0] row_en     [NUM_ROWS] = '{2'b11, 2'b01, 2'b11, 2'b11, 2'b10, 2'b11};
    int         row_window [NUM_ROWS] = '{200, 160, 100, 64, 120, 90};

    // Slow edge index and pulse bookkeeping
    int cyc = 0;
    int wr_cyc = 0;
    int slow_cnt = 0;
    int slow_total = 0;
    int first_cyc = 0;
    int last_cyc = 0;
    int min_gap = 0;
    int max_gap = 0;
    int fast_xssi_cnt = 0;
    int fast_pap_cnt = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    timers_pkg::apb_data_t rd_data;
    logic                  rd_err;

    timers_top i_timers_top (
        .clk_15p36               (clk_15p36),
        .clk_368p64              (clk_368p64),
        .arst_n                  (arst_n),
        .psel                    (psel),
        .penable                 (penable),
        .pwrite                  (pwrite),
        .paddr                   (paddr),
        .pwdata                  (pwdata),
        .prdata                  (prdata),
        .pslverr                 (pslverr),
        .timer_pulse_xssi        (timer_pulse_xssi),
        .timer_pulse_xssi_x3     (timer_pulse_xssi_x3),
        .timer_pulse_tssi_pap_x3 (timer_pulse_tssi_pap_x3)
    );

    initial begin
        clk_15p36 = 1'b0;
        forever #5 clk_15p36 = ~clk_15p36;
    end

    // Fast clock, offset so it is not phase-locked to the slow one
    initial begin
        clk_368p64 = 1'b0;
        #0.137;
        forever #0.208 clk_368p64 = ~clk_368p64;
    end

    // Slow pulse count, first arrival and gap range
    always @(posedge clk_15p36) begin
        cyc = cyc + 1;
        if (timer_pulse_xssi === 1'b1) begin
            if (slow_cnt == 0) begin
                first_cyc = cyc;
            end else begin
                if (cyc - last_cyc < min_gap) begin
                    min_gap = cyc - last_cyc;
                end
                if (cyc - last_cyc > max_gap) begin
                    max_gap = cyc - last_cyc;
                end
            end
            last_cyc   = cyc;
            slow_cnt   = slow_cnt + 1;
            slow_total = slow_total + 1;
        end
    end

    // Fast strobe tallies
    always @(posedge clk_368p64) begin
        if (timer_pulse_xssi_x3 === 1'b1) begin
            fast_xssi_cnt = fast_xssi_cnt + 1;
        end
        if (timer_pulse_tssi_pap_x3 === 1'b1) begin
            fast_pap_cnt = fast_pap_cnt + 1;
        end
    end

    // Watchdog sized from the table
    initial begin
        int limit;
        limit = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit = limit + row_window[r] + 200;
        end
        #(limit * 10);
        $display("Timeout: run did not finish within %0d slow cycles", limit);
        $display("CHECKS FAILED");
        $finish;
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Setup then access phase, entered 1 ns after a rising edge
    task automatic apb_access(input logic wr, input timers_pkg::apb_addr_t addr,
                              input timers_pkg::apb_data_t data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk_15p36);
        #1;
        penable = 1'b1;
        // Response sampled just ahead of the access edge
        #8;
        rd_data = prdata;
        rd_err  = pslverr;
        @(posedge clk_15p36);
        #1;
        wr_cyc  = cyc;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input timers_pkg::apb_addr_t addr, input timers_pkg::apb_data_t data);
        apb_access(1'b1, addr, data);
    endtask

    task automatic apb_read(input timers_pkg::apb_addr_t addr);
        apb_access(1'b0, addr, '0);
    endtask

    task automatic flag_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("** Error: %s got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        errors = errors + 1;
    endtask

    task automatic read_expect(input timers_pkg::apb_addr_t addr, input logic [31:0] exp,
                               input logic exp_err, input string name);
        apb_read(addr);
        if (rd_data !== exp) begin
            flag_value({"prdata ", name}, rd_data, exp);
        end
        if (rd_err !== exp_err) begin
            flag_value({"pslverr ", name}, rd_err, exp_err);
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run = tests_run + 1;
        if (errors > err_before) begin
            tests_failed = tests_failed + 1;
            $display("test %s: %0d error(s)", name, errors - err_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    initial begin
        int          err0;
        int          exp_x;
        int          exp_p;
        int          en_cyc;
        logic [31:0] rnd;
        logic [31:0] tics_mask;
        tics_mask = (32'h1 << `TIMER_TICS_BW) - 1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        arst_n    = 1'b0;
        repeat (16) @(posedge clk_15p36);
        #1;
        arst_n = 1'b1;
        repeat (2) @(posedge clk_15p36);
        #1;

        err0 = errors;
        read_expect(`REG_XSSI_TICS, `XSSI_TICS_DEFAULT, 1'b0, "XSSI_TICS");
        read_expect(`REG_PAP_TICS, `PAP_TICS_DEFAULT, 1'b0, "PAP_TICS");
        read_expect(`REG_CTRL, 32'h0, 1'b0, "CTRL");
        read_expect(`REG_XSSI_COUNT, 32'h0, 1'b0, "XSSI_COUNT");
        finish_test("reset defaults", err0);

        // Error responses, then masked readback of random data
        err0 = errors;
        read_expect(8'h10, 32'h0, 1'b1, "offset 0x10");
        apb_write(8'h10, 32'hffff_ffff);
        if (rd_err !== 1'b1) begin
            flag_value("pslverr write 0x10", rd_err, 1'b1);
        end
        apb_write(`REG_XSSI_COUNT, 32'h0000_1234);
        if (rd_err !== 1'b1) begin
            flag_value("pslverr write XSSI_COUNT", rd_err, 1'b1);
        end
        read_expect(`REG_XSSI_COUNT, 32'h0, 1'b0, "XSSI_COUNT");
        rnd = next_random(32'h2a04f911);
        apb_write(`REG_XSSI_TICS, rnd);
        read_expect(`REG_XSSI_TICS, rnd & tics_mask, 1'b0, "XSSI_TICS");
        rnd = next_random(rnd);
        apb_write(`REG_PAP_TICS, rnd);
        read_expect(`REG_PAP_TICS, rnd & tics_mask, 1'b0, "PAP_TICS");
        rnd = next_random(rnd);
        apb_write(`REG_CTRL, rnd);
        read_expect(`REG_CTRL, rnd & 32'h3, 1'b0, "CTRL");
        apb_write(`REG_CTRL, 32'h0);
        finish_test("register access", err0);

        for (int r = 0; r < NUM_ROWS; r++) begin
            err0 = errors;
            apb_write(`REG_XSSI_TICS, row_xssi_n[r]);
            apb_write(`REG_PAP_TICS, row_pap_n[r]);
            repeat (SETTLE) @(posedge clk_15p36);
            #1;
            slow_cnt      = 0;
            first_cyc     = 0;
            min_gap       = 32'h7fff_ffff;
            max_gap       = 0;
            fast_xssi_cnt = 0;
            fast_pap_cnt  = 0;
            apb_write(`REG_CTRL, row_en[r]);
            en_cyc = wr_cyc;
            // Disable lands on the window's last edge but one
            repeat (row_window[r] - 3) @(posedge clk_15p36);
            #1;
            apb_write(`REG_CTRL, 32'h0);
            repeat (SETTLE) @(posedge clk_15p36);
            #1;
            exp_x = (row_en[r][0] && row_xssi_n[r] != 0) ? row_window[r] / row_xssi_n[r] : 0;
            exp_p = (row_en[r][1] && row_pap_n[r] != 0) ? row_window[r] / row_pap_n[r] : 0;
            if (slow_cnt != exp_x) begin
                flag_value("timer_pulse_xssi count", slow_cnt, exp_x);
            end
            if (exp_x > 0 && first_cyc - en_cyc != row_xssi_n[r]) begin
                flag_value("timer_pulse_xssi first delay", first_cyc - en_cyc, row_xssi_n[r]);
            end
            if (exp_x > 1 && min_gap != row_xssi_n[r]) begin
                flag_value("timer_pulse_xssi min gap", min_gap, row_xssi_n[r]);
            end
            if (exp_x > 1 && max_gap != row_xssi_n[r]) begin
                flag_value("timer_pulse_xssi max gap", max_gap, row_xssi_n[r]);
            end
            if (fast_xssi_cnt != slow_cnt) begin
                flag_value("timer_pulse_xssi_x3 count", fast_xssi_cnt, slow_cnt);
            end
            if (fast_pap_cnt != exp_p) begin
                flag_value("timer_pulse_tssi_pap_x3 count", fast_pap_cnt, exp_p);
            end
            finish_test($sformatf("row %0d", r), err0);
        end

        err0 = errors;
        read_expect(`REG_XSSI_COUNT, slow_total & 32'hffff, 1'b0, "XSSI_COUNT");
        finish_test("final count", err0);

        errors = errors + i_timers_top.i_timers_assertions.assert_fails;
        $display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, i_timers_top.i_timers_assertions.assert_fails);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- verification/timers_assertions.sv
// Concurrent checks bound into timers_top
// Slow pulse check covers XSSI only, the one slow tick visible at this level
`timescale 1ns/1ps
`include "timers_consts.svh"

module timers_assertions (
    input logic                  clk_15p36,
    input logic                  clk_368p64,
    input logic                  arst_n,
    input logic                  psel,
    input logic                  penable,
    input logic                  pwrite,
    input timers_pkg::apb_addr_t paddr,
    input logic                  pslverr,
    input logic                  xssi_en,
    input logic                  timer_pulse_xssi,
    input logic                  timer_pulse_xssi_x3,
    input logic                  timer_pulse_tssi_pap_x3
);

    // Failure tally read by the testbench
    int assert_fails = 0;

    // Offset outside the register map
    logic bad_offset;

    assign bad_offset = !(paddr inside {`REG_XSSI_TICS, `REG_PAP_TICS,
                                        `REG_CTRL, `REG_XSSI_COUNT});

    // Fast strobes last one clk_368p64 cycle
    xssi_x3_one_cycle: assert property (@(posedge clk_368p64) disable iff (!arst_n)
        timer_pulse_xssi_x3 |=> !timer_pulse_xssi_x3)
    else begin
        $error("timer_pulse_xssi_x3 high for more than one fast cycle");
        assert_fails++;
    end

    pap_x3_one_cycle: assert property (@(posedge clk_368p64) disable iff (!arst_n)
        timer_pulse_tssi_pap_x3 |=> !timer_pulse_tssi_pap_x3)
    else begin
        $error("timer_pulse_tssi_pap_x3 high for more than one fast cycle");
        assert_fails++;
    end

    // Registered pulse may trail the enable by one cycle
    xssi_pulse_needs_en: assert property (@(posedge clk_15p36) disable iff (!arst_n)
        timer_pulse_xssi |-> $past(xssi_en))
    else begin
        $error("timer_pulse_xssi high with xssi_en low");
        assert_fails++;
    end

    // Error response only in the access phase, for a bad offset or a count write
    pslverr_in_access: assert property (@(posedge clk_15p36) disable iff (!arst_n)
        pslverr == (psel && penable &&
                    (bad_offset || (pwrite && paddr == `REG_XSSI_COUNT))))
    else begin
        $error("pslverr does not match the access phase and register map");
        assert_fails++;
    end

endmodule

bind timers_top timers_assertions i_timers_assertions (
    .clk_15p36               (clk_15p36),
    .clk_368p64              (clk_368p64),
    .arst_n                  (arst_n),
    .psel                    (psel),
    .penable                 (penable),
    .pwrite                  (pwrite),
    .paddr                   (paddr),
    .pslverr                 (pslverr),
    .xssi_en                 (xssi_en),
    .timer_pulse_xssi        (timer_pulse_xssi),
    .timer_pulse_xssi_x3     (timer_pulse_xssi_x3),
    .timer_pulse_tssi_pap_x3 (timer_pulse_tssi_pap_x3)
);

//--- hw/timers_top.sv
// Measurement timer subsystem, APB in clk_15p36, strobes in clk_368p64
// arst_n reaches both domains unsynchronized, release away from edges
`timescale 1ns/1ps

module timers_top (
    input  logic                  clk_15p36,
    input  logic                  clk_368p64,
    input  logic                  arst_n,
    // APB slave
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  timers_pkg::apb_addr_t paddr,
    input  timers_pkg::apb_data_t pwdata,
    output timers_pkg::apb_data_t prdata,
    output logic                  pslverr,
    // Tick outputs
    output logic                  timer_pulse_xssi,
    output logic                  timer_pulse_xssi_x3,
    output logic                  timer_pulse_tssi_pap_x3
);

    // Register block to timers
    timers_pkg::tics_t xssi_tics;
    timers_pkg::tics_t pap_tics;
    logic              xssi_en;
    logic              pap_en;

    // Register decode, XSSI pulse count fed back from the timers
    timer_regs u_timer_regs (
        .clk_15p36        (clk_15p36),
        .arst_n           (arst_n),
        .psel             (psel),
        .penable          (penable),
        .pwrite           (pwrite),
        .paddr            (paddr),
        .pwdata           (pwdata),
        .prdata           (prdata),
        .pslverr          (pslverr),
        .timer_pulse_xssi (timer_pulse_xssi),
        .xssi_tics        (xssi_tics),
        .pap_tics         (pap_tics),
        .xssi_en          (xssi_en),
        .pap_en           (pap_en)
    );

    // Period counters and fast strobes
    timers u_timers (
        .clk_15p36               (clk_15p36),
        .clk_368p64              (clk_368p64),
        .arst_n                  (arst_n),
        .xssi_en                 (xssi_en),
        .pap_en                  (pap_en),
        .xssi_tics               (xssi_tics),
        .pap_tics                (pap_tics),
        .timer_pulse_xssi        (timer_pulse_xssi),
        .timer_pulse_xssi_x3     (timer_pulse_xssi_x3),
        .timer_pulse_tssi_pap_x3 (timer_pulse_tssi_pap_x3)
    );

endmodule

//--- hw/timer_regs.sv
// APB register block in clk_15p36; no wait states, no pready
// Unmapped offsets and writes to the count register return pslverr
`timescale 1ns/1ps
`include "timers_consts.svh"

module timer_regs (
    input  logic                  clk_15p36,
    input  logic                  arst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  timers_pkg::apb_addr_t paddr,
    input  timers_pkg::apb_data_t pwdata,
    output timers_pkg::apb_data_t prdata,
    output logic                  pslverr,
    input  logic                  timer_pulse_xssi,
    output timers_pkg::tics_t     xssi_tics,
    output timers_pkg::tics_t     pap_tics,
    output logic                  xssi_en,
    output logic                  pap_en
);

    // Access phase strobe
    logic                  access;
    // Offset decodes to a register
    logic                  addr_ok;
    // Offset is the read-only count
    logic                  addr_ro;
    // Accepted write
    logic                  wr_en;
    // Running XSSI pulse count
    timers_pkg::xssi_cnt_t xssi_cnt;

    // Second cycle of the transfer, completes on this edge
    assign access = psel & penable;

    // Address decode
    always_comb begin
        addr_ok = 1'b0;
        addr_ro = 1'b0;
        case (paddr)
            `REG_XSSI_TICS,
            `REG_PAP_TICS,
            `REG_CTRL: begin
                addr_ok = 1'b1;
            end
            `REG_XSSI_COUNT: begin
                addr_ok = 1'b1;
                addr_ro = 1'b1;
            end
            default: begin
                addr_ok = 1'b0;
            end
        endcase
    end

    // Error on unmapped offset or write to read-only count
    assign pslverr = access & (~addr_ok | (pwrite & addr_ro));

    // Erroring writes are dropped
    assign wr_en = access & pwrite & ~pslverr;

    // Period and control registers
    always_ff @(posedge clk_15p36 or negedge arst_n) begin
        if (!arst_n) begin
            xssi_tics <= timers_pkg::tics_t'(`XSSI_TICS_DEFAULT);
            pap_tics  <= timers_pkg::tics_t'(`PAP_TICS_DEFAULT);
            xssi_en   <= 1'b0;
            pap_en    <= 1'b0;
        end else if (wr_en) begin
            case (paddr)
                `REG_XSSI_TICS: begin
                    xssi_tics <= pwdata[`TIMER_TICS_BW-1:0];
                end
                `REG_PAP_TICS: begin
                    pap_tics <= pwdata[`TIMER_TICS_BW-1:0];
                end
                `REG_CTRL: begin
                    xssi_en <= pwdata[`CTRL_XSSI_EN_BIT];
                    pap_en  <= pwdata[`CTRL_PAP_EN_BIT];
                end
                default: begin
                    xssi_en <= xssi_en;
                end
            endcase
        end
    end

    // One count per slow XSSI pulse, lands the cycle after it
    always_ff @(posedge clk_15p36 or negedge arst_n) begin
        if (!arst_n) begin
            xssi_cnt <= '0;
        end else if (timer_pulse_xssi) begin
            xssi_cnt <= xssi_cnt + 1'b1;
        end
    end

    // Read mux, zero outside a read access phase
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                `REG_XSSI_TICS: begin
                    prdata = timers_pkg::apb_data_t'(xssi_tics);
                end
                `REG_PAP_TICS: begin
                    prdata = timers_pkg::apb_data_t'(pap_tics);
                end
                `REG_CTRL: begin
                    prdata[`CTRL_XSSI_EN_BIT] = xssi_en;
                    prdata[`CTRL_PAP_EN_BIT]  = pap_en;
                end
                `REG_XSSI_COUNT: begin
                    prdata = timers_pkg::apb_data_t'(xssi_cnt);
                end
                default: begin
                    prdata = '0;
                end
            endcase
        end
    end

endmodule

//--- hw/timers.sv
// XSSI and PA-overdrive period timers with fast-domain strobes
// Slow pulses must last several fast cycles for the synchronizers
`timescale 1ns/1ps

module timers (
    input  logic              clk_15p36,
    input  logic              clk_368p64,
    input  logic              arst_n,
    input  logic              xssi_en,
    input  logic              pap_en,
    input  timers_pkg::tics_t xssi_tics,
    input  timers_pkg::tics_t pap_tics,
    output logic              timer_pulse_xssi,
    output logic              timer_pulse_xssi_x3,
    output logic              timer_pulse_tssi_pap_x3
);

    // PA-overdrive tick, slow domain only
    logic timer_pulse_pap;

    // XSSI/RSSI period, default 100 ms
    // Slow tick also feeds the RSSI meters and the pulse count
    timer_pulse u_timer_xssi (
        .clk_15p36   (clk_15p36),
        .arst_n      (arst_n),
        .en          (xssi_en),
        .max_count   (xssi_tics),
        .timer_pulse (timer_pulse_xssi)
    );

    // XSSI tick into the fast domain
    pulse_edge_sync u_sync_xssi (
        .clk_368p64 (clk_368p64),
        .arst_n     (arst_n),
        .din        (timer_pulse_xssi),
        .dout       (timer_pulse_xssi_x3)
    );

    // PA-overdrive averaging period, default about 10 us
    timer_pulse u_timer_pap (
        .clk_15p36   (clk_15p36),
        .arst_n      (arst_n),
        .en          (pap_en),
        .max_count   (pap_tics),
        .timer_pulse (timer_pulse_pap)
    );

    // TSSI PAP tick into the fast domain
    pulse_edge_sync u_sync_pap (
        .clk_368p64 (clk_368p64),
        .arst_n     (arst_n),
        .din        (timer_pulse_pap),
        .dout       (timer_pulse_tssi_pap_x3)
    );

endmodule

//--- hw/pulse_edge_sync.sv
// Slow pulse to one-cycle clk_368p64 strobe, 3 to 4 fast cycles late
// Input pulse must be wider than two fast cycles
`timescale 1ns/1ps

module pulse_edge_sync (
    input  logic clk_368p64,
    input  logic arst_n,
    input  logic din,
    output logic dout
);

    // Synchronizer stages
    logic sync_q1;
    logic sync_q2;
    // Previous synchronized level
    logic sync_q3;
    logic rise;

    // Two-flop synchronizer plus one history flop
    always_ff @(posedge clk_368p64 or negedge arst_n) begin
        if (!arst_n) begin
            sync_q1 <= 1'b0;
            sync_q2 <= 1'b0;
            sync_q3 <= 1'b0;
        end else begin
            sync_q1 <= din;
            sync_q2 <= sync_q1;
            sync_q3 <= sync_q2;
        end
    end

    // Rising edge of the synchronized level
    assign rise = sync_q2 & ~sync_q3;

    // Retimed single-cycle strobe
    always_ff @(posedge clk_368p64 or negedge arst_n) begin
        if (!arst_n) begin
            dout <= 1'b0;
        end else begin
            dout <= rise;
        end
    end

endmodule

//--- hw/timer_pulse.sv
// Period tick generator; one-cycle pulse every max_count cycles
// Zero period or low enable holds the counter at zero
`timescale 1ns/1ps

module timer_pulse (
    input  logic              clk_15p36,
    input  logic              arst_n,
    input  logic              en,
    input  timers_pkg::tics_t max_count,
    output logic              timer_pulse
);

    // Tic counter, 0 to max_count-1
    timers_pkg::tics_t cnt;
    timers_pkg::tics_t cnt_next;
    // Last seen period, for change detection
    timers_pkg::tics_t max_count_q;
    logic              run;
    logic              restart;

    // Counting needs enable and a nonzero period
    assign run     = en && (max_count != '0);
    // Period rewritten since last cycle
    assign restart = (max_count != max_count_q);

    // Wrap at terminal count, >= guards a shrunk period
    always_comb begin
        if (cnt >= max_count - 1'b1) begin
            cnt_next = '0;
        end else begin
            cnt_next = cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_15p36 or negedge arst_n) begin
        if (!arst_n) begin
            cnt         <= '0;
            max_count_q <= '0;
            timer_pulse <= 1'b0;
        end else begin
            max_count_q <= max_count;
            if (!run || restart) begin
                // Hold or restart from zero
                cnt         <= '0;
                timer_pulse <= 1'b0;
            end else begin
                cnt         <= cnt_next;
                // High while count sits at N-1
                timer_pulse <= (cnt_next == max_count - 1'b1);
            end
        end
    end

endmodule

//--- hw/timers_pkg.sv
// Vector types shared by the timer subsystem
// Widths follow the consts header, so change them there only
package timers_pkg;

`include "timers_consts.svh"

    // Period length in 15.36 MHz tics
    typedef logic [`TIMER_TICS_BW-1:0] tics_t;

    // APB byte address
    typedef logic [`APB_ADDR_BW-1:0] apb_addr_t;

    // APB read or write data word
    typedef logic [`APB_DATA_BW-1:0] apb_data_t;

    // XSSI pulse count, wraps at 2^16
    typedef logic [`XSSI_CNT_BW-1:0] xssi_cnt_t;

endpackage

//--- hw/timers_consts.svh
// Widths, APB register offsets and reset periods for the measurement timers
// Periods are in 15.36 MHz tics; offsets are full 8-bit byte addresses
`ifndef TIMERS_CONSTS_SVH
`define TIMERS_CONSTS_SVH

// Period counter width, enough for the 100 ms default
`define TIMER_TICS_BW 21
// 100 ms at 15.36 MHz
`define XSSI_TICS_DEFAULT 1536000
// Roughly 10 us at 15.36 MHz
`define PAP_TICS_DEFAULT 154

// APB bus widths
`define APB_ADDR_BW 8
`define APB_DATA_BW 32

// Wrapping XSSI pulse count
`define XSSI_CNT_BW 16

// Register offsets
`define REG_XSSI_TICS 8'h00
`define REG_PAP_TICS 8'h04
`define REG_CTRL 8'h08
`define REG_XSSI_COUNT 8'h0C

// Control register bit positions
`define CTRL_XSSI_EN_BIT 0
`define CTRL_PAP_EN_BIT 1

`endif
